//--- hw/aux_ctrl_unit.sv
`include "aux_defs.svh"

module aux_ctrl_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                spm_req_vld,
    input  aux_pkg::aux_req_t   spm_req,
    input  logic                lpm_req_vld,
    input  aux_pkg::aux_req_t   lpm_req,
    input  aux_pkg::aux_reply_t reply,
    input  logic                timer_timeout,
    output logic                send,
    output aux_pkg::aux_req_t   send_req,
    output aux_pkg::aux_reply_t spm_reply,
    output aux_pkg::aux_reply_t lpm_reply,
    output logic                ctrl_native_failed
);

    import aux_pkg::*;

    localparam int RETRY_W = $clog2(`AUX_MAX_RETRIES + 1);

    ctrl_state_e          state;
    aux_req_t             req_q;
    logic                 owner_lpm;
    logic [RETRY_W-1:0]   retry_cnt;
    logic                 retry_req;
    logic                 accept;

    assign accept = (state == IDLE) && (spm_req_vld || lpm_req_vld);

    // a defer or a lost reply both ask for another attempt
    assign retry_req = (state == WAIT_REPLY) &&
                       ((reply.ack_vld && reply.ack == DEFER) ||
                        (!reply.ack_vld && timer_timeout));

    // hold off while trailing reply bytes still arrive
    assign send     = (state == SEND) && !reply.data_vld;
    assign send_req = req_q;

    // request payload, lpm has priority
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= lpm_req_vld ? lpm_req : spm_req;
        end
    end

    // ==================================================
    // transaction FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state              <= IDLE;
            owner_lpm          <= 1'b0;
            retry_cnt          <= '0;
            ctrl_native_failed <= 1'b0;
        end else begin
            ctrl_native_failed <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        owner_lpm <= lpm_req_vld;
                        retry_cnt <= '0;
                        state     <= SEND;
                    end
                end
                SEND: begin
                    if (send) begin
                        state <= WAIT_REPLY;
                    end
                end
                WAIT_REPLY: begin
                    if (retry_req) begin
                        if (retry_cnt < RETRY_W'(`AUX_MAX_RETRIES)) begin
                            retry_cnt <= retry_cnt + 1'b1;
                            state     <= SEND;
                        end else begin
                            // out of retries
                            ctrl_native_failed <= 1'b1;
                            state              <= IDLE;
                        end
                    end else if (reply.ack_vld) begin
                        // ack, nack or an unknown code closes the transaction
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // reply goes to the owner only
    always_comb begin
        spm_reply = '0;
        lpm_reply = '0;
        if (owner_lpm) begin
            lpm_reply = reply;
        end else begin
            spm_reply = reply;
        end
    end

endmodule

//--- hw/aux_pkg.sv
`include "aux_defs.svh"

package aux_pkg;

    // native request codes, upper nibble of the first header byte
    typedef enum logic [3:0] {
        NATIVE_WRITE = 4'b1000,
        NATIVE_READ  = 4'b1001
    } aux_cmd_e;

    // reply codes, upper nibble of the first reply byte
    typedef enum logic [3:0] {
        ACK   = 4'b0000,
        NACK  = 4'b0001,
        DEFER = 4'b0010
    } reply_ack_e;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_REPLY
    } ctrl_state_e;

    typedef struct packed {
        aux_cmd_e                cmd;
        logic [`AUX_ADDR_W-1:0] address;
        logic [`AUX_BYTE_W-1:0] len;
        logic [`AUX_BYTE_W-1:0] data;
    } aux_req_t;

    typedef struct packed {
        logic                   ack_vld;
        reply_ack_e             ack;
        logic                   data_vld;
        logic [`AUX_BYTE_W-1:0] data;
    } aux_reply_t;

endpackage

//--- hw/dp_source.sv
`include "aux_defs.svh"

module dp_source (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   spm_req_vld,
    input  aux_pkg::aux_req_t      spm_req,
    input  logic                   lpm_req_vld,
    input  aux_pkg::aux_req_t      lpm_req,
    output logic [`AUX_BYTE_W-1:0] aux_out,
    output logic                   aux_start_stop,
    input  logic [`AUX_BYTE_W-1:0] aux_in,
    input  logic                   phy_start_stop,
    input  logic                   hpd_signal,
    output aux_pkg::aux_reply_t    spm_reply,
    output aux_pkg::aux_reply_t    lpm_reply,
    output logic                   timer_timeout,
    output logic                   ctrl_native_failed,
    output logic                   hpd_detect,
    output logic                   hpd_irq
);

    import aux_pkg::*;

    // control unit to encoder
    logic       send;
    aux_req_t   send_req;

    // decoder to control unit
    aux_reply_t reply;

    // ==================================================
    // aux transaction path
    // ==================================================
    aux_ctrl_unit aux_ctrl_unit_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .spm_req_vld        (spm_req_vld),
        .spm_req            (spm_req),
        .lpm_req_vld        (lpm_req_vld),
        .lpm_req            (lpm_req),
        .reply              (reply),
        .timer_timeout      (timer_timeout),
        .send               (send),
        .send_req           (send_req),
        .spm_reply          (spm_reply),
        .lpm_reply          (lpm_reply),
        .ctrl_native_failed (ctrl_native_failed)
    );

    native_message_encoder native_message_encoder_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .send           (send),
        .send_req       (send_req),
        .aux_out        (aux_out),
        .aux_start_stop (aux_start_stop)
    );

    reply_decoder reply_decoder_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .aux_in         (aux_in),
        .phy_start_stop (phy_start_stop),
        .reply          (reply)
    );

    timeout_timer timeout_timer_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .aux_start_stop (aux_start_stop),
        .phy_start_stop (phy_start_stop),
        .timer_timeout  (timer_timeout)
    );

    // ==================================================
    // hot plug detect
    // ==================================================
    hpd hpd_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .hpd_signal (hpd_signal),
        .hpd_detect (hpd_detect),
        .hpd_irq    (hpd_irq)
    );

endmodule

//--- hw/hpd.sv
`include "aux_defs.svh"

module hpd (
    input  logic clk,
    input  logic rst_n,
    input  logic hpd_signal,
    output logic hpd_detect,
    output logic hpd_irq
);

    // plug time is the longest of the thresholds
    localparam int CNT_W = $clog2(`HPD_PLUG_CYCLES + 1);

    logic [CNT_W-1:0] high_cnt;
    logic [CNT_W-1:0] low_cnt;
    logic             irq_run;

    // short low pulse seen while plugged
    assign irq_run = (low_cnt != '0) && (low_cnt <= CNT_W'(`HPD_IRQ_MAX_CYCLES));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hpd_detect <= 1'b0;
            hpd_irq    <= 1'b0;
            high_cnt   <= '0;
            low_cnt    <= '0;
        end else begin
            hpd_irq <= 1'b0;
            if (!hpd_detect) begin
                // ==================================================
                // waiting for a stable plug
                // ==================================================
                low_cnt <= '0;
                if (!hpd_signal) begin
                    high_cnt <= '0;
                end else if (high_cnt == CNT_W'(`HPD_PLUG_CYCLES - 1)) begin
                    hpd_detect <= 1'b1;
                    high_cnt   <= '0;
                end else begin
                    high_cnt <= high_cnt + 1'b1;
                end
            end else if (!hpd_signal) begin
                // ==================================================
                // plugged, line low
                // ==================================================
                if (low_cnt == CNT_W'(`HPD_UNPLUG_CYCLES - 1)) begin
                    hpd_detect <= 1'b0;
                    low_cnt    <= '0;
                end else begin
                    low_cnt <= low_cnt + 1'b1;
                end
            end else begin
                // line back high, longer runs are ignored
                hpd_irq <= irq_run;
                low_cnt <= '0;
            end
        end
    end

endmodule

//--- hw/native_message_encoder.sv
`include "aux_defs.svh"

module native_message_encoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   send,
    input  aux_pkg::aux_req_t      send_req,
    output logic [`AUX_BYTE_W-1:0] aux_out,
    output logic                   aux_start_stop
);

    import aux_pkg::*;

    localparam int W = `AUX_BYTE_W;

    typedef enum logic {
        ENC_IDLE,
        ENC_SHIFT
    } enc_state_e;

    enc_state_e       state;
    logic [2:0]       bytes_left;
    logic [4*W-1:0]   tail_q;
    logic             load;
    logic             shift;

    assign load  = (state == ENC_IDLE) && send;
    assign shift = (state == ENC_SHIFT) && (bytes_left != 3'd0);

    // ==================================================
    // framing
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ENC_IDLE;
            bytes_left     <= 3'd0;
            aux_start_stop <= 1'b0;
        end else if (load) begin
            state          <= ENC_SHIFT;
            aux_start_stop <= 1'b1;
            // header is 4 bytes, writes add one data byte
            bytes_left     <= (send_req.cmd == NATIVE_WRITE) ? 3'd4 : 3'd3;
        end else if (shift) begin
            bytes_left <= bytes_left - 3'd1;
        end else if (state == ENC_SHIFT) begin
            // last byte has been on the line for a cycle
            state          <= ENC_IDLE;
            aux_start_stop <= 1'b0;
        end
    end

    // byte shifter
    always_ff @(posedge clk) begin
        if (load) begin
            aux_out <= {send_req.cmd, send_req.address[19:16]};
            tail_q  <= {send_req.address[15:8], send_req.address[7:0],
                        send_req.len, send_req.data};
        end else if (shift) begin
            aux_out <= tail_q[4*W-1 -: W];
            tail_q  <= tail_q << W;
        end
    end

endmodule

//--- hw/reply_decoder.sv
`include "aux_defs.svh"

module reply_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`AUX_BYTE_W-1:0] aux_in,
    input  logic                   phy_start_stop,
    output aux_pkg::aux_reply_t    reply
);

    import aux_pkg::*;

    logic                   in_burst;
    logic                   ack_byte;
    logic                   data_byte;
    logic                   ack_vld_q;
    logic                   data_vld_q;
    reply_ack_e             ack_q;
    logic [`AUX_BYTE_W-1:0] data_q;

    // first byte of a burst carries the reply code
    assign ack_byte  = phy_start_stop && !in_burst;
    assign data_byte = phy_start_stop && in_burst;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_burst   <= 1'b0;
            ack_vld_q  <= 1'b0;
            data_vld_q <= 1'b0;
        end else begin
            in_burst   <= phy_start_stop;
            ack_vld_q  <= ack_byte;
            data_vld_q <= data_byte;
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (ack_byte) begin
            ack_q <= reply_ack_e'(aux_in[7:4]);
        end
        if (data_byte) begin
            data_q <= aux_in;
        end
    end

    assign reply.ack_vld  = ack_vld_q;
    assign reply.ack      = ack_q;
    assign reply.data_vld = data_vld_q;
    assign reply.data     = data_q;

endmodule

//--- hw/timeout_timer.sv
`include "aux_defs.svh"

module timeout_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic aux_start_stop,
    input  logic phy_start_stop,
    output logic timer_timeout
);

    localparam int TMO_W = $clog2(`AUX_REPLY_TIMEOUT);

    logic             start_stop_q;
    logic             armed;
    logic [TMO_W-1:0] count;
    logic             frame_end;

    assign frame_end = start_stop_q && !aux_start_stop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_stop_q  <= 1'b0;
            armed         <= 1'b0;
            count         <= '0;
            timer_timeout <= 1'b0;
        end else begin
            start_stop_q  <= aux_start_stop;
            timer_timeout <= 1'b0;
            if (frame_end) begin
                armed <= 1'b1;
                count <= TMO_W'(`AUX_REPLY_TIMEOUT - 1);
            end else if (phy_start_stop) begin
                // sink has started answering
                armed <= 1'b0;
            end else if (armed) begin
                if (count == '0) begin
                    timer_timeout <= 1'b1;
                    armed         <= 1'b0;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

endmodule

//--- include/aux_defs.svh
`ifndef AUX_DEFS_SVH
`define AUX_DEFS_SVH

// ==================================================
// aux channel widths
// ==================================================
`define AUX_ADDR_W 20
`define AUX_BYTE_W 8

// ==================================================
// transaction timing
// ==================================================
// wait cycles after a request frame before giving up on the reply
`define AUX_REPLY_TIMEOUT 64
// retransmissions allowed after the first attempt
`define AUX_MAX_RETRIES 3

// ==================================================
// hot plug thresholds, in clk cycles
// ==================================================
`define HPD_PLUG_CYCLES 32
`define HPD_IRQ_MAX_CYCLES 16
`define HPD_UNPLUG_CYCLES 24

`endif

//--- list.f
+incdir+include
hw/aux_pkg.sv
hw/hpd.sv
hw/timeout_timer.sv
hw/reply_decoder.sv
hw/native_message_encoder.sv
hw/aux_ctrl_unit.sv
hw/dp_source.sv
verification/tb_dp_source.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_dp_source -o tb_dp_source \
    && ./obj_dir/tb_dp_source | tee /dev/stderr | grep -q "^Test completed successfully$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verification/dp_source_tests.txt
# AUX name requester(S/L/B) cmd addr len data outcome(ACK/NACK/FAIL) attempt1..attempt4
#   attempt: A/N/D plus data byte count, S silent, - unused; HPD name low_cycles
AUX spm_read_ack      S 9 12345 02 00 ACK  A3 -  -  -
AUX spm_write_ack     S 8 0a0f0 00 5c ACK  A0 -  -  -
AUX lpm_read_ack      L 9 fedcb 01 00 ACK  A2 -  -  -
AUX lpm_write_nack    L 8 00100 00 a5 NACK N0 -  -  -
AUX spm_read_nack     S 9 00202 00 00 NACK N0 -  -  -
AUX spm_defer_ack     S 9 40080 01 00 ACK  D0 A2 -  -
AUX lpm_defer_data    L 8 00333 00 3c ACK  D1 D0 A0 -
AUX spm_silent_ack    S 9 7ffff 00 00 ACK  S  A1 -  -
AUX lpm_mixed_retry   L 9 12000 03 00 ACK  D0 S  D2 A4
AUX spm_exhaust       S 8 00001 00 11 FAIL S  S  S  S
AUX lpm_exhaust_defer L 9 abcde 00 00 FAIL D0 S  D0 S
AUX both_read         B 9 5a5a5 01 00 ACK  A2 -  -  -
AUX both_write        B 8 00fe0 00 77 NACK N0 -  -  -
HPD hpd_irq_short     5
HPD hpd_mid_low       20
HPD hpd_irq_max       16
HPD hpd_unplug        30
HPD hpd_replug_irq    1
AUX spm_after_hpd     S 9 000ff 00 00 ACK  A1 -  -  -
AUX lpm_last_defer    L 8 f0000 00 e1 ACK  D0 D0 D0 A0

//--- verification/tb_dp_source.sv
`include "aux_defs.svh"

module tb_dp_source;

    import aux_pkg::*;

    localparam int MAX_TESTS = 32;
    localparam int SETTLE    = 4;
    localparam int HPD_TAIL  = 8;

    logic                   clk;
    logic                   rst_n;
    logic                   spm_req_vld;
    aux_req_t               spm_req;
    logic                   lpm_req_vld;
    aux_req_t               lpm_req;
    logic [`AUX_BYTE_W-1:0] aux_out;
    logic                   aux_start_stop;
    logic [`AUX_BYTE_W-1:0] aux_in;
    logic                   phy_start_stop;
    logic                   hpd_signal;
    aux_reply_t             spm_reply;
    aux_reply_t             lpm_reply;
    logic                   timer_timeout;
    logic                   ctrl_native_failed;
    logic                   hpd_detect;
    logic                   hpd_irq;

    // test table from the data file
    int       n_tests;
    string    t_kind [MAX_TESTS];
    string    t_name [MAX_TESTS];
    string    t_req  [MAX_TESTS];
    aux_req_t t_aux  [MAX_TESTS];
    int       t_exp  [MAX_TESTS];
    string    t_act  [MAX_TESTS][4];
    int       t_low  [MAX_TESTS];

    string cur_name;
    int    errors;
    int    checks;
    int    cycles;
    int    cycle_limit;

    dp_source dut (.*);

    always #20 clk = ~clk;

    // watchdog armed once the limit is known
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic compare(string what, int exp, int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("ERROR %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
        end
    endtask

    task automatic report_problem(string msg);
        errors++;
        $display("%s: %s", cur_name, msg);
    endtask

    // reply code of a sink action with -1 for unused and -2 for silent
    function automatic int act_code(string a);
        if (a.getc(0) == "A") return int'(ACK);
        if (a.getc(0) == "N") return int'(NACK);
        if (a.getc(0) == "D") return int'(DEFER);
        if (a.getc(0) == "S") return -2;
        return -1;
    endfunction

    function automatic int act_bytes(string a);
        return (a.len() > 1) ? a.substr(1, a.len() - 1).atoi() : 0;
    endfunction

    // ==================================================
    // data file reader
    // ==================================================
    task automatic read_tests(output bit ok);
        int          fd;
        int          n;
        int          k;
        string       line;
        string       kind;
        string       exp_s;
        logic [3:0]  cmd;
        logic [19:0] addr;
        logic [7:0]  len;
        logic [7:0]  data;
        ok = 1'b0;
        n_tests = 0;
        fd = $fopen("verification/dp_source_tests.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                kind = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s", kind);
                if (kind == "AUX") begin
                    n = $sscanf(line, "%s %s %s %h %h %h %h %s %s %s %s %s", kind,
                                t_name[n_tests], t_req[n_tests], cmd, addr, len, data, exp_s,
                                t_act[n_tests][0], t_act[n_tests][1], t_act[n_tests][2],
                                t_act[n_tests][3]);
                    if (n != 12) begin
                        $display("malformed test line: %s", line);
                        errors++;
                    end
                    t_aux[n_tests].cmd     = aux_cmd_e'(cmd);
                    t_aux[n_tests].address = addr;
                    t_aux[n_tests].len     = len;
                    t_aux[n_tests].data    = data;
                    t_exp[n_tests] = (exp_s == "ACK") ? 0 : (exp_s == "NACK") ? 1 :
                                     (exp_s == "FAIL") ? 2 : -1;
                    t_kind[n_tests] = kind;
                    n_tests++;
                end else if (kind == "HPD") begin
                    n = $sscanf(line, "%s %s %d", kind, t_name[n_tests], t_low[n_tests]);
                    t_kind[n_tests] = kind;
                    n_tests++;
                end
            end
            $fclose(fd);
            // attempts, plug times and low pulses plus reset and slack
            cycle_limit = 200;
            for (int i = 0; i < n_tests; i++) begin
                if (t_kind[i] == "AUX") begin
                    for (k = 0; k < 4; k++) begin
                        if (act_code(t_act[i][k]) != -1) begin
                            cycle_limit += 5 + `AUX_REPLY_TIMEOUT + 1 +
                                           act_bytes(t_act[i][k]) + 10;
                        end
                    end
                end else begin
                    cycle_limit += t_low[i] + `HPD_PLUG_CYCLES + 2 * HPD_TAIL;
                end
            end
        end
    endtask

    // ==================================================
    // one AUX transaction with the sink model
    // ==================================================
    task automatic run_aux(int i);
        aux_req_t   req;
        aux_req_t   decoy;
        aux_reply_t own;
        aux_reply_t other;
        logic [7:0] exp_frame [$];
        logic [7:0] got_frame [$];
        logic [7:0] exp_data [$];
        logic [7:0] tx [$];
        int         exp_ack [$];
        int         tcyc, first_cyc, att, n_att, n_silent, tmos, fails;
        int         outcome, sink_cnt, settle, code, nb, k;
        logic       lpm_owns, sending, prev_ss;
        req = t_aux[i];
        decoy = req;
        decoy.address = req.address ^ 20'h0f0f0;
        decoy.len = req.len + 8'd1;
        lpm_owns = (t_req[i] != "S");
        n_att = 0;
        n_silent = 0;
        for (k = 0; k < 4; k++) begin
            if (act_code(t_act[i][k]) != -1) n_att++;
            if (act_code(t_act[i][k]) == -2) n_silent++;
        end
        // cmd and address high nibble then address, len and write data
        exp_frame.push_back({req.cmd, req.address[19:16]});
        exp_frame.push_back(req.address[15:8]);
        exp_frame.push_back(req.address[7:0]);
        exp_frame.push_back(req.len);
        if (req.cmd == NATIVE_WRITE) exp_frame.push_back(req.data);
        spm_req_vld = (t_req[i] != "L");
        spm_req     = (t_req[i] == "B") ? decoy : req;
        lpm_req_vld = (t_req[i] != "S");
        lpm_req     = req;
        tcyc = 0;
        first_cyc = 0;
        att = 0;
        tmos = 0;
        fails = 0;
        sink_cnt = 0;
        settle = 0;
        outcome = -1;
        sending = 1'b0;
        prev_ss = 1'b0;
        while (settle < SETTLE) begin
            next_cycle();
            tcyc++;
            spm_req_vld = 1'b0;
            lpm_req_vld = 1'b0;
            if (sending) begin
                if (tx.size() > 0) begin
                    aux_in = tx.pop_front();
                end else begin
                    phy_start_stop = 1'b0;
                    aux_in = '0;
                    sending = 1'b0;
                end
            end
            // sink answers 3 cycles after the frame ends
            if (sink_cnt > 0) begin
                sink_cnt--;
                code = (sink_cnt == 0 && att <= n_att) ? act_code(t_act[i][att - 1]) : -2;
                if (sink_cnt == 0 && code >= 0) begin
                    nb = act_bytes(t_act[i][att - 1]);
                    tx.push_back({code[3:0], 4'h0});
                    exp_ack.push_back(code);
                    for (k = 0; k < nb; k++) begin
                        tx.push_back(req.address[7:0] + 8'(k));
                        exp_data.push_back(req.address[7:0] + 8'(k));
                    end
                    phy_start_stop = 1'b1;
                    aux_in = tx.pop_front();
                    sending = 1'b1;
                end
            end
            if (aux_start_stop) begin
                if (got_frame.size() == 0 && att == 0) first_cyc = tcyc;
                got_frame.push_back(aux_out);
            end else if (prev_ss) begin
                if (att >= n_att) report_problem("frame sent after the last expected attempt");
                compare($sformatf("frame %0d length", att), exp_frame.size(), got_frame.size());
                for (k = 0; k < got_frame.size() && k < exp_frame.size(); k++) begin
                    compare($sformatf("frame %0d byte %0d", att, k), exp_frame[k], got_frame[k]);
                end
                if (att == 0) compare("request to first byte cycles", 2, first_cyc);
                got_frame = {};
                att++;
                sink_cnt = 3;
            end
            prev_ss = aux_start_stop;
            if (timer_timeout) tmos++;
            if (ctrl_native_failed) begin
                fails++;
                outcome = 2;
            end
            own   = lpm_owns ? lpm_reply : spm_reply;
            other = lpm_owns ? spm_reply : lpm_reply;
            if (other.ack_vld || other.data_vld) begin
                report_problem("reply valid on the port that does not own the transaction");
            end
            if (own.ack_vld) begin
                if (exp_ack.size() == 0) report_problem("ack seen with no reply sent");
                else compare("ack", exp_ack.pop_front(), int'(own.ack));
                if (own.ack != DEFER) outcome = int'(own.ack);
            end
            if (own.data_vld) begin
                if (exp_data.size() == 0) report_problem("data byte seen with none sent");
                else compare("data", exp_data.pop_front(), own.data);
            end
            if (outcome >= 0 && !sending && sink_cnt == 0) settle++;
        end
        compare("outcome", t_exp[i], outcome);
        compare("frames", n_att, att);
        compare("timer_timeout pulses", n_silent, tmos);
        compare("ctrl_native_failed pulses", (t_exp[i] == 2) ? 1 : 0, fails);
        if (exp_data.size() != 0) report_problem("reply data bytes missing");
        if (got_frame.size() != 0) report_problem("frame started after the transaction ended");
    endtask

    // ==================================================
    // hot plug pulse
    // ==================================================
    task automatic run_hpd(int i);
        int wait_cyc;
        int irqs;
        int k;
        int low;
        low = t_low[i];
        if (!hpd_detect) begin
            hpd_signal = 1'b1;
            wait_cyc = 0;
            while (!hpd_detect) begin
                next_cycle();
                wait_cyc++;
            end
            compare("plug cycles", `HPD_PLUG_CYCLES, wait_cyc);
        end
        irqs = 0;
        hpd_signal = 1'b0;
        for (k = 0; k < low; k++) begin
            next_cycle();
            if (hpd_irq) irqs++;
        end
        hpd_signal = 1'b1;
        for (k = 0; k < HPD_TAIL; k++) begin
            next_cycle();
            if (hpd_irq) irqs++;
        end
        compare("hpd_detect", (low < `HPD_UNPLUG_CYCLES) ? 1 : 0, hpd_detect);
        compare("hpd_irq pulses", (low >= 1 && low <= `HPD_IRQ_MAX_CYCLES) ? 1 : 0, irqs);
        // unplugged sink stays away until the next plug
        if (!hpd_detect) begin
            hpd_signal = 1'b0;
            next_cycle();
        end
    endtask

    initial begin
        bit ok;
        clk = 1'b0;
        rst_n = 1'b0;
        spm_req_vld = 1'b0;
        spm_req = '0;
        lpm_req_vld = 1'b0;
        lpm_req = '0;
        aux_in = '0;
        phy_start_stop = 1'b0;
        hpd_signal = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        cycle_limit = 0;
        cur_name = "reset";
        read_tests(ok);
        if (!ok) begin
            $display("cannot open verification/dp_source_tests.txt");
            $display("Test failed");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            #2;
            rst_n = 1'b1;
            compare("outputs after reset", 0, {aux_start_stop, timer_timeout,
                    ctrl_native_failed, hpd_detect, hpd_irq, spm_reply.ack_vld,
                    spm_reply.data_vld, lpm_reply.ack_vld, lpm_reply.data_vld});
            for (int i = 0; i < n_tests; i++) begin
                cur_name = t_name[i];
                if (t_kind[i] == "AUX") run_aux(i);
                else run_hpd(i);
            end
            $display("tests: %0d, checks: %0d, errors: %0d", n_tests, checks, errors);
            if (errors == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule
